// File: pipeCtrl_consts.svh
`ifndef PIPE_CTRL_CONSTS_SVH
`define PIPE_CTRL_CONSTS_SVH

// Width of the fetch redirect target.
`define PC_WIDTH 64

// Decode-to-issue queue sizing.
`define QUEUE_DEPTH 8
`define QUEUE_HIGH 6
`define QCNT_WIDTH 4

// Stages that carry a valid bit, F2 through W.
`define STAGE_COUNT 7

`endif

// File: pipeCtrlPkg.sv
package pipeCtrlPkg;

    typedef struct packed {
        logic stallF;
        logic stallF2;
        logic flushF2;
        logic stallD;
        logic flushD;
        logic stallI;
        logic stallIDe;     // Holds the decode side of the issue queue.
        logic flushI;
        logic flushQue;     // Empties the decode-to-issue queue.
        logic stallE;
        logic flushE;
        logic stallM;
        logic flushM;
        logic stallM2;
        logic flushM2;
        logic flushW;
        logic redirectPend; // A late flush still waits on the I-cache.
    } stageCtrl_t;

    typedef struct packed {
        logic iWait;
        logic dWait;
        logic eWait;
    } waitReq_t;

    typedef struct packed {
        logic branchM;
        logic excpM;
        logic excpW;
    } pipeEvent_t;

    // Encoded in priority order below causeNone.
    typedef enum logic [2:0] {
        causeNone,
        causeExcpW,
        causeExcpM,
        causeDWait,
        causeBranch,
        causeEWait,
        causeOverflow,
        causeIWait
    } hazardCause_t;

    typedef struct packed {
        logic vF2;
        logic vD;
        logic vI;
        logic vE;
        logic vM;
        logic vM2;
        logic vW;
    } stageValid_t;

endpackage

// File: hazardUnit.sv
`timescale 1ns/1ps

module hazardUnit (
    input  logic                      clk,
    input  logic                      reset,
    input  pipeCtrlPkg::waitReq_t     waits,
    input  pipeCtrlPkg::pipeEvent_t   events,
    input  logic                      overflowI,
    output pipeCtrlPkg::stageCtrl_t   ctrl,
    output pipeCtrlPkg::hazardCause_t cause
);

    logic excpPend;
    logic excpPendNxt;
    logic branchPend;
    logic branchPendNxt;

    // Squash everything younger than M, including the issue queue.
    function automatic pipeCtrlPkg::stageCtrl_t squashFront(
        input pipeCtrlPkg::stageCtrl_t c
    );
        pipeCtrlPkg::stageCtrl_t r;
        r          = c;
        r.flushF2  = 1'b1;
        r.flushD   = 1'b1;
        r.flushI   = 1'b1;
        r.flushE   = 1'b1;
        r.flushM   = 1'b1;
        r.flushQue = 1'b1;
        return r;
    endfunction

    always_ff @(posedge clk) begin
        if (reset) begin
            excpPend   <= 1'b0;
            branchPend <= 1'b0;
        end else begin
            excpPend   <= excpPendNxt;
            branchPend <= branchPendNxt;
        end
    end

    always_comb begin
        ctrl          = '0;
        cause         = pipeCtrlPkg::causeNone;
        excpPendNxt   = excpPend;
        branchPendNxt = branchPend;

        if (events.excpW || events.excpM) begin
            ctrl = squashFront(ctrl);
            if (events.excpW) begin
                ctrl.flushM2 = 1'b1; // Trap at W also kills M2 and W.
                ctrl.flushW  = 1'b1;
                cause        = pipeCtrlPkg::causeExcpW;
            end else begin
                cause = pipeCtrlPkg::causeExcpM;
            end
            if (waits.iWait) begin
                excpPendNxt = 1'b1; // Fetch busy. Flush again once it frees.
            end
        end else if (waits.dWait) begin
            ctrl.stallF   = 1'b1;
            ctrl.stallF2  = 1'b1;
            ctrl.stallD   = 1'b1;
            ctrl.stallI   = 1'b1;
            ctrl.stallIDe = 1'b1;
            ctrl.stallE   = 1'b1;
            ctrl.stallM   = 1'b1;
            ctrl.flushM2  = 1'b1; // Bubble behind the held M stage.
            cause         = pipeCtrlPkg::causeDWait;
        end else if (events.branchM) begin
            ctrl  = squashFront(ctrl);
            cause = pipeCtrlPkg::causeBranch;
            if (waits.iWait) begin
                ctrl.stallF   = 1'b1;
                branchPendNxt = 1'b1;
            end
        end else if (waits.eWait) begin
            ctrl.stallF   = 1'b1;
            ctrl.stallF2  = 1'b1;
            ctrl.stallD   = 1'b1;
            ctrl.stallI   = 1'b1;
            ctrl.stallIDe = 1'b1;
            ctrl.stallE   = 1'b1;
            ctrl.flushM   = 1'b1; // Bubble behind the held E stage.
            cause         = pipeCtrlPkg::causeEWait;
        end else if (overflowI) begin
            ctrl.stallF  = 1'b1;
            ctrl.stallF2 = 1'b1;
            ctrl.stallI  = 1'b1;
            ctrl.stallD  = 1'b1;
            cause        = pipeCtrlPkg::causeOverflow;
        end else if (waits.iWait) begin
            ctrl.stallF  = 1'b1;
            ctrl.flushF2 = 1'b1; // Nothing valid arrives from the I-cache.
            cause        = pipeCtrlPkg::causeIWait;
        end

        // Late flushes for redirects that met a busy I-cache.
        if (!ctrl.stallF && excpPend) begin
            ctrl.flushF2 = 1'b1;
            ctrl.flushD  = 1'b1;
            excpPendNxt  = 1'b0;
        end
        if (!(waits.iWait || waits.eWait) && branchPend) begin
            ctrl.flushF2  = 1'b1;
            ctrl.flushD   = 1'b1;
            branchPendNxt = 1'b0;
        end

        ctrl.redirectPend = excpPend | branchPend;
    end

    // The issue stage must die whenever the queue feeding it is emptied.
    flushQueNeedsFlushI : assert property (
        @(posedge clk) disable iff (reset)
        $rose(ctrl.flushQue) |-> ctrl.flushI
    ) else $error("flushQue rose without flushI.");

endmodule

// File: issueQueueTracker.sv
`timescale 1ns/1ps
`include "pipeCtrl_consts.svh"

module issueQueueTracker (
    input  logic                    clk,
    input  logic                    reset,
    input  pipeCtrlPkg::stageCtrl_t ctrl,
    input  logic                    decodeValid,
    input  logic                    issueTake,
    output logic [`QCNT_WIDTH-1:0]  queueCount,
    output logic                    nonEmpty,
    output logic                    overflowI
);

    logic push;
    logic pop;

    assign push = decodeValid && !ctrl.stallD && !ctrl.flushD; // D hands one entry over.
    assign pop  = issueTake && nonEmpty;

    always_ff @(posedge clk) begin
        if (reset) begin
            queueCount <= '0;
        end else if (ctrl.flushQue) begin
            queueCount <= '0; // Flush beats push and pop.
        end else begin
            case ({push, pop})
                2'b10:   queueCount <= queueCount + `QCNT_WIDTH'(1);
                2'b01:   queueCount <= queueCount - `QCNT_WIDTH'(1);
                default: queueCount <= queueCount;
            endcase
        end
    end

    assign nonEmpty  = (queueCount != '0);
    assign overflowI = (queueCount >= `QCNT_WIDTH'(`QUEUE_HIGH)); // Early warning to hazard.

    // The overflow stall on D must keep the queue from ever running past its depth.
    countWithinDepth : assert property (
        @(posedge clk) disable iff (reset)
        queueCount <= `QCNT_WIDTH'(`QUEUE_DEPTH)
    ) else $error("Issue queue count %0d exceeds depth.", queueCount);

endmodule

// File: redirectUnit.sv
`timescale 1ns/1ps
`include "pipeCtrl_consts.svh"

module redirectUnit (
    input  logic                      clk,
    input  logic                      reset,
    input  pipeCtrlPkg::stageCtrl_t   ctrl,
    input  pipeCtrlPkg::hazardCause_t cause,
    input  logic [`PC_WIDTH-1:0]      branchTarget,
    input  logic [`PC_WIDTH-1:0]      trapVector,
    output logic                      redirectValid,
    output logic [`PC_WIDTH-1:0]      redirectPc
);

    logic take;
    logic isBranch;

    assign isBranch = (cause == pipeCtrlPkg::causeBranch);
    assign take     = isBranch || (cause == pipeCtrlPkg::causeExcpW)
                    || (cause == pipeCtrlPkg::causeExcpM);

    always_ff @(posedge clk) begin
        if (take) begin
            redirectPc <= isBranch ? branchTarget : trapVector;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            redirectValid <= 1'b0;
        end else if (take) begin
            redirectValid <= 1'b1;
        end else if (!ctrl.stallF) begin
            redirectValid <= 1'b0; // Fetch has accepted the target.
        end
    end

    // Fetch may still be waiting, so the target must not move under it.
    pcHeldWhileStalled : assert property (
        @(posedge clk) disable iff (reset)
        (redirectValid && ctrl.stallF && !take) |=> $stable(redirectPc)
    ) else $error("redirectPc changed while fetch was stalled.");

endmodule

// File: stageValidTracker.sv
`timescale 1ns/1ps
`include "pipeCtrl_consts.svh"

module stageValidTracker (
    input  logic                     clk,
    input  logic                     reset,
    input  pipeCtrlPkg::stageCtrl_t  ctrl,
    input  logic                     fetchValid,
    input  logic                     queueNonEmpty,
    output pipeCtrlPkg::stageValid_t valid
);

    logic [`STAGE_COUNT-1:0]  validQ;
    pipeCtrlPkg::stageValid_t cur;
    pipeCtrlPkg::stageValid_t nxt;

    // Flush first, then stall, then advance.
    function automatic logic stepBit(
        input logic flush,
        input logic stall,
        input logic hold,
        input logic src
    );
        if (flush) begin
            return 1'b0;
        end
        if (stall) begin
            return hold;
        end
        return src;
    endfunction

    assign cur   = pipeCtrlPkg::stageValid_t'(validQ);
    assign valid = cur;

    always_comb begin
        nxt.vF2 = stepBit(ctrl.flushF2, ctrl.stallF2, cur.vF2, fetchValid & ~ctrl.stallF);
        nxt.vD  = stepBit(ctrl.flushD, ctrl.stallD, cur.vD, cur.vF2 & ~ctrl.stallF2);
        nxt.vI  = stepBit(ctrl.flushI, ctrl.stallI, cur.vI, queueNonEmpty & ~ctrl.stallI);
        nxt.vE  = stepBit(ctrl.flushE, ctrl.stallE, cur.vE, cur.vI & ~ctrl.stallI);
        nxt.vM  = stepBit(ctrl.flushM, ctrl.stallM, cur.vM, cur.vE & ~ctrl.stallE);
        nxt.vM2 = stepBit(ctrl.flushM2, 1'b0, cur.vM2, cur.vM & ~ctrl.stallM); // No M2 stall.
        nxt.vW  = stepBit(ctrl.flushW, 1'b0, cur.vW, cur.vM2);
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            validQ <= '0;
        end else begin
            validQ <= nxt;
        end
    end

endmodule

// File: pipeCtrlTop.sv
`timescale 1ns/1ps
`include "pipeCtrl_consts.svh"

module pipeCtrlTop (
    input  logic                      clk,
    input  logic                      reset,
    input  pipeCtrlPkg::waitReq_t     waits,
    input  pipeCtrlPkg::pipeEvent_t   events,
    input  logic                      fetchValid,
    input  logic                      issueTake,
    input  logic [`PC_WIDTH-1:0]      branchTarget,
    input  logic [`PC_WIDTH-1:0]      trapVector,
    output pipeCtrlPkg::stageCtrl_t   ctrl,
    output pipeCtrlPkg::hazardCause_t cause,
    output pipeCtrlPkg::stageValid_t  valid,
    output logic [`QCNT_WIDTH-1:0]    queueCount,
    output logic                      redirectValid,
    output logic [`PC_WIDTH-1:0]      redirectPc
);

    logic overflowI;
    logic queueNonEmpty; // Queue feeds the issue stage.

    hazardUnit i_hazardUnit (
        .clk       (clk),
        .reset     (reset),
        .waits     (waits),
        .events    (events),
        .overflowI (overflowI),
        .ctrl      (ctrl),
        .cause     (cause)
    );

    issueQueueTracker i_issueQueueTracker (
        .clk         (clk),
        .reset       (reset),
        .ctrl        (ctrl),
        .decodeValid (valid.vD),
        .issueTake   (issueTake),
        .queueCount  (queueCount),
        .nonEmpty    (queueNonEmpty),
        .overflowI   (overflowI)
    );

    redirectUnit i_redirectUnit (
        .clk           (clk),
        .reset         (reset),
        .ctrl          (ctrl),
        .cause         (cause),
        .branchTarget  (branchTarget),
        .trapVector    (trapVector),
        .redirectValid (redirectValid),
        .redirectPc    (redirectPc)
    );

    stageValidTracker i_stageValidTracker (
        .clk           (clk),
        .reset         (reset),
        .ctrl          (ctrl),
        .fetchValid    (fetchValid),
        .queueNonEmpty (queueNonEmpty),
        .valid         (valid)
    );

endmodule

// File: pipeCtrlTb.sv
`timescale 1ns/1ps
`include "pipeCtrl_consts.svh"

module pipeCtrlTb;

    localparam int numRows = 28;
    localparam int randCycles = 300;

    // Ctrl bits from the MSB are F F2 fF2 | D fD | I IDe fI fQue | E fE | M fM | M2 fM2 fW | pend.
    localparam logic [16:0] ctlIdle   = 17'b000_00_0000_00_00_000_0;
    localparam logic [16:0] ctlExcpM  = 17'b001_01_0011_01_01_000_0;
    localparam logic [16:0] ctlExcpW  = 17'b001_01_0011_01_01_011_0;
    localparam logic [16:0] ctlDWait  = 17'b110_10_1100_10_10_010_0;
    localparam logic [16:0] ctlBrWait = 17'b101_01_0011_01_01_000_0;
    localparam logic [16:0] ctlEWait  = 17'b110_10_1100_10_01_000_0;
    localparam logic [16:0] ctlOvf    = 17'b110_10_1000_00_00_000_0;
    localparam logic [16:0] ctlIWait  = 17'b101_00_0000_00_00_000_0;
    localparam logic [16:0] ctlLate   = 17'b001_01_0000_00_00_000_1;
    localparam logic [16:0] pend      = 17'b000_00_0000_00_00_000_1;

    typedef struct packed {
        pipeCtrlPkg::waitReq_t     waits;
        pipeCtrlPkg::pipeEvent_t   events;
        logic                      fetchValid;
        logic                      issueTake;
        pipeCtrlPkg::stageCtrl_t   expCtrl;
        pipeCtrlPkg::hazardCause_t expCause;
    } stimRow_t;

    logic                      clk = 1'b0;
    logic                      reset;
    pipeCtrlPkg::waitReq_t     waits;
    pipeCtrlPkg::pipeEvent_t   events;
    logic                      fetchValid;
    logic                      issueTake;
    logic [`PC_WIDTH-1:0]      branchTarget;
    logic [`PC_WIDTH-1:0]      trapVector;
    pipeCtrlPkg::stageCtrl_t   ctrl;
    pipeCtrlPkg::hazardCause_t cause;
    pipeCtrlPkg::stageValid_t  valid;
    logic [`QCNT_WIDTH-1:0]    queueCount;
    logic                      redirectValid;
    logic [`PC_WIDTH-1:0]      redirectPc;

    stimRow_t                  rows [numRows];
    int                        errors = 0;
    int                        checks = 0;
    int                        seedDummy;

    // Reference model state.
    pipeCtrlPkg::stageCtrl_t   mCtrl;
    pipeCtrlPkg::hazardCause_t mCause;
    pipeCtrlPkg::stageValid_t  mValid;
    logic [`QCNT_WIDTH-1:0]    mCount;
    logic                      mExcpPend;
    logic                      mExcpNxt;
    logic                      mBranchPend;
    logic                      mBranchNxt;
    logic                      mRedValid;
    logic [`PC_WIDTH-1:0]      mRedPc;

    pipeCtrlTop i_pipeCtrlTop (
        .clk           (clk),
        .reset         (reset),
        .waits         (waits),
        .events        (events),
        .fetchValid    (fetchValid),
        .issueTake     (issueTake),
        .branchTarget  (branchTarget),
        .trapVector    (trapVector),
        .ctrl          (ctrl),
        .cause         (cause),
        .valid         (valid),
        .queueCount    (queueCount),
        .redirectValid (redirectValid),
        .redirectPc    (redirectPc)
    );

    always #5 clk = ~clk;

    task automatic setRow(input int idx, input logic [2:0] w, input logic [2:0] e,
                          input logic fv, input logic take, input logic [16:0] c,
                          input pipeCtrlPkg::hazardCause_t cs);
        rows[idx].waits      = w;
        rows[idx].events     = e;
        rows[idx].fetchValid = fv;
        rows[idx].issueTake  = take;
        rows[idx].expCtrl    = c;
        rows[idx].expCause   = cs;
    endtask

    task automatic reportMismatch(input string name, input logic [63:0] expVal,
                                  input logic [63:0] actVal);
        errors++;
        $display("MISMATCH at %0t ns: %s expected %h, got %h", $time, name, expVal, actVal);
    endtask

    // Priority rule and pending flushes for the current inputs.
    task automatic modelCtrl();
        pipeCtrlPkg::stageCtrl_t c;
        c          = '0;
        mCause     = pipeCtrlPkg::causeNone;
        mExcpNxt   = mExcpPend;
        mBranchNxt = mBranchPend;
        if (events.excpW || events.excpM) begin
            {c.flushF2, c.flushD, c.flushI, c.flushE, c.flushM, c.flushQue} = 6'b111111;
            c.flushM2 = events.excpW;
            c.flushW  = events.excpW;
            mCause    = events.excpW ? pipeCtrlPkg::causeExcpW : pipeCtrlPkg::causeExcpM;
            mExcpNxt  = mExcpPend | waits.iWait;
        end else if (waits.dWait) begin
            {c.stallF, c.stallF2, c.stallD, c.stallI, c.stallIDe, c.stallE, c.stallM} = 7'h7f;
            c.flushM2 = 1'b1;
            mCause    = pipeCtrlPkg::causeDWait;
        end else if (events.branchM) begin
            {c.flushF2, c.flushD, c.flushI, c.flushE, c.flushM, c.flushQue} = 6'b111111;
            c.stallF   = waits.iWait;
            mBranchNxt = mBranchPend | waits.iWait;
            mCause     = pipeCtrlPkg::causeBranch;
        end else if (waits.eWait) begin
            {c.stallF, c.stallF2, c.stallD, c.stallI, c.stallIDe, c.stallE} = 6'h3f;
            c.flushM = 1'b1;
            mCause   = pipeCtrlPkg::causeEWait;
        end else if (mCount >= `QCNT_WIDTH'(`QUEUE_HIGH)) begin
            {c.stallF, c.stallF2, c.stallD, c.stallI} = 4'hf;
            mCause = pipeCtrlPkg::causeOverflow;
        end else if (waits.iWait) begin
            c.stallF  = 1'b1;
            c.flushF2 = 1'b1;
            mCause    = pipeCtrlPkg::causeIWait;
        end
        if (!c.stallF && mExcpPend) begin
            {c.flushF2, c.flushD} = 2'b11;
            mExcpNxt = 1'b0;
        end
        if (!waits.iWait && !waits.eWait && mBranchPend) begin
            {c.flushF2, c.flushD} = 2'b11;
            mBranchNxt = 1'b0;
        end
        c.redirectPend = mExcpPend | mBranchPend;
        mCtrl = c;
    endtask

    // Advances the valid chain, queue counter, redirect and pending states by one edge.
    task automatic modelAdvance();
        pipeCtrlPkg::stageCtrl_t  c;
        pipeCtrlPkg::stageValid_t v;
        pipeCtrlPkg::stageValid_t n;
        logic                     push;
        logic                     pop;
        logic                     take;
        c     = mCtrl;
        v     = mValid;
        push  = v.vD && !c.stallD && !c.flushD;
        pop   = issueTake && (mCount != '0);
        n.vF2 = c.flushF2 ? 1'b0 : (c.stallF2 ? v.vF2 : fetchValid & ~c.stallF);
        n.vD  = c.flushD ? 1'b0 : (c.stallD ? v.vD : v.vF2 & ~c.stallF2);
        n.vI  = c.flushI ? 1'b0 : (c.stallI ? v.vI : (mCount != '0) & ~c.stallI);
        n.vE  = c.flushE ? 1'b0 : (c.stallE ? v.vE : v.vI & ~c.stallI);
        n.vM  = c.flushM ? 1'b0 : (c.stallM ? v.vM : v.vE & ~c.stallE);
        n.vM2 = c.flushM2 ? 1'b0 : v.vM & ~c.stallM;
        n.vW  = c.flushW ? 1'b0 : v.vM2;
        mValid = n;
        if (c.flushQue) begin
            mCount = '0;
        end else if (push && !pop) begin
            mCount = mCount + `QCNT_WIDTH'(1);
        end else if (pop && !push) begin
            mCount = mCount - `QCNT_WIDTH'(1);
        end
        take = (mCause == pipeCtrlPkg::causeExcpW) || (mCause == pipeCtrlPkg::causeExcpM)
             || (mCause == pipeCtrlPkg::causeBranch);
        if (take) begin
            mRedPc    = (mCause == pipeCtrlPkg::causeBranch) ? branchTarget : trapVector;
            mRedValid = 1'b1;
        end else if (!c.stallF) begin
            mRedValid = 1'b0;
        end
        mExcpPend   = mExcpNxt;
        mBranchPend = mBranchNxt;
    endtask

    task automatic checkState();
        checks++;
        if (valid !== mValid) reportMismatch("valid", 64'(mValid), 64'(valid));
        if (queueCount !== mCount) reportMismatch("queueCount", 64'(mCount), 64'(queueCount));
        if (redirectValid !== mRedValid) begin
            reportMismatch("redirectValid", 64'(mRedValid), 64'(redirectValid));
        end
        if (mRedValid && redirectPc !== mRedPc) reportMismatch("redirectPc", mRedPc, redirectPc);
    endtask

    initial begin
        #((numRows + randCycles + 20) * 10);
        $display("Timeout: the run did not reach its end within the expected time.");
        $display("Result: FAILED");
        $finish;
    end

    initial begin
        seedDummy    = $urandom(46464);
        reset        = 1'b1;
        waits        = '0;
        events       = '0;
        fetchValid   = 1'b0;
        issueTake    = 1'b0;
        branchTarget = '0;
        trapVector   = '0;
        {mExcpPend, mBranchPend, mRedValid} = 3'b000;
        mValid = '0;
        mCount = '0;
        mRedPc = '0;
        setRow(0, 3'b000, 3'b000, 1'b0, 1'b0, ctlIdle, pipeCtrlPkg::causeNone);
        setRow(1, 3'b010, 3'b010, 1'b0, 1'b0, ctlExcpM, pipeCtrlPkg::causeExcpM);
        setRow(2, 3'b000, 3'b001, 1'b0, 1'b0, ctlExcpW, pipeCtrlPkg::causeExcpW);
        setRow(3, 3'b001, 3'b100, 1'b0, 1'b0, ctlExcpM, pipeCtrlPkg::causeBranch);
        setRow(4, 3'b100, 3'b000, 1'b0, 1'b0, ctlIWait, pipeCtrlPkg::causeIWait);
        setRow(5, 3'b000, 3'b000, 1'b0, 1'b0, ctlIdle, pipeCtrlPkg::causeNone);
        setRow(6, 3'b100, 3'b100, 1'b0, 1'b0, ctlBrWait, pipeCtrlPkg::causeBranch);
        setRow(7, 3'b100, 3'b000, 1'b0, 1'b0, ctlIWait | pend, pipeCtrlPkg::causeIWait);
        setRow(8, 3'b001, 3'b000, 1'b0, 1'b0, ctlEWait | pend, pipeCtrlPkg::causeEWait);
        setRow(9, 3'b000, 3'b000, 1'b0, 1'b0, ctlLate, pipeCtrlPkg::causeNone);
        setRow(10, 3'b011, 3'b100, 1'b0, 1'b0, ctlDWait, pipeCtrlPkg::causeDWait);
        setRow(11, 3'b100, 3'b010, 1'b0, 1'b0, ctlExcpM, pipeCtrlPkg::causeExcpM);
        setRow(12, 3'b100, 3'b000, 1'b0, 1'b0, ctlIWait | pend, pipeCtrlPkg::causeIWait);
        setRow(13, 3'b000, 3'b000, 1'b0, 1'b0, ctlLate, pipeCtrlPkg::causeNone);
        setRow(14, 3'b000, 3'b000, 1'b0, 1'b0, ctlIdle, pipeCtrlPkg::causeNone);
        for (int r = 15; r < 23; r++) begin
            setRow(r, 3'b000, 3'b000, 1'b1, 1'b0, ctlIdle, pipeCtrlPkg::causeNone); // Fill queue.
        end
        setRow(23, 3'b100, 3'b000, 1'b1, 1'b0, ctlOvf, pipeCtrlPkg::causeOverflow);
        setRow(24, 3'b000, 3'b000, 1'b1, 1'b1, ctlOvf, pipeCtrlPkg::causeOverflow);
        setRow(25, 3'b000, 3'b000, 1'b1, 1'b0, ctlIdle, pipeCtrlPkg::causeNone);
        setRow(26, 3'b000, 3'b010, 1'b1, 1'b0, ctlExcpM, pipeCtrlPkg::causeExcpM);
        setRow(27, 3'b000, 3'b000, 1'b0, 1'b0, ctlIdle, pipeCtrlPkg::causeNone);

        repeat (3) @(posedge clk);
        #1;
        reset = 1'b0;
        for (int i = 0; i < numRows + randCycles; i++) begin
            branchTarget = {$urandom, $urandom};
            trapVector   = {$urandom, $urandom};
            if (i < numRows) begin
                waits      = rows[i].waits;
                events     = rows[i].events;
                fetchValid = rows[i].fetchValid;
                issueTake  = rows[i].issueTake;
            end else begin
                waits.iWait     = ($urandom % 4) == 0;
                waits.dWait     = ($urandom % 6) == 0;
                waits.eWait     = ($urandom % 5) == 0;
                events.branchM  = ($urandom % 8) == 0;
                events.excpM    = ($urandom % 12) == 0;
                events.excpW    = ($urandom % 16) == 0;
                fetchValid      = ($urandom % 4) != 0;
                issueTake       = ($urandom % 3) == 0; // Slow drain lets the queue fill.
            end
            @(negedge clk);
            modelCtrl();
            if (i < numRows) begin
                if (ctrl !== rows[i].expCtrl) begin
                    reportMismatch("ctrl", 64'(rows[i].expCtrl), 64'(ctrl));
                end
                if (cause !== rows[i].expCause) begin
                    reportMismatch("cause", 64'(rows[i].expCause), 64'(cause));
                end
            end else begin
                if (ctrl !== mCtrl) reportMismatch("ctrl", 64'(mCtrl), 64'(ctrl));
                if (cause !== mCause) reportMismatch("cause", 64'(mCause), 64'(cause));
            end
            checkState();
            modelAdvance();
            @(posedge clk);
            #1;
        end

        $display("Checked %0d cycles, %0d errors.", checks, errors);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

// File: pipeCtrl.f
+incdir+.
pipeCtrlPkg.sv
hazardUnit.sv
issueQueueTracker.sv
redirectUnit.sv
stageValidTracker.sv
pipeCtrlTop.sv
pipeCtrlTb.sv

// File: runSim.sh
#!/bin/sh
# Builds and runs the pipeline control testbench with Verilator.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f pipeCtrl.f --top-module pipeCtrlTb
if [ $? -ne 0 ]; then
    echo "Verilator build failed."
    exit 1
fi

out=$(./obj_dir/VpipeCtrlTb)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status."
    exit 1
fi

if echo "$out" | grep -q "Result: PASSED"; then
    exit 0
fi
exit 1
